// ==== spu_pkg.sv ====
`default_nettype none

package spu_pkg;

    // word offsets inside the register window
    typedef enum logic [2:0] {
        REG_SRC    = 3'd0,  // source base
        REG_DST    = 3'd1,  // destination base
        REG_LEN    = 3'd2,  // element count
        REG_ADDEND = 3'd3,  // operand
        REG_CTRL   = 3'd4,  // start and op select
        REG_STATUS = 3'd5   // busy and done
    } spu_reg_e;

    // per-element operation
    typedef enum logic [1:0] {
        OP_COPY = 2'd0,
        OP_ADDS = 2'd1,  // clips at all ones
        OP_SUBS = 2'd2,  // clips at zero
        OP_XOR  = 2'd3
    } spu_op_e;

    localparam int CTRL_START_BIT  = 0;  // write one to start
    localparam int CTRL_OP_LSB     = 1;  // two op bits from here

    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;  // sticky until next start

endpackage

`default_nettype wire

// ==== spu_op_nop.sv ====
`default_nettype none

module spu_op_nop #(
    parameter int  LATENCY = 1,
    parameter type data_t  = logic [7:0]
) (
    input  var logic  clk,
    input  var data_t in_data,
    output data_t     out_data
);

    if (LATENCY == 0) begin : g_pass
        assign out_data = in_data;  // no stages, straight through
    end else begin : g_pipe
        data_t stages [LATENCY];

        always_ff @(posedge clk) begin
            stages[0] <= in_data;
            for (int i = 1; i < LATENCY; i++) begin
                stages[i] <= stages[i-1];  // shift one stage on
            end
        end

        assign out_data = stages[LATENCY-1];
    end

endmodule

`default_nettype wire

// ==== spu_op_mem_sp.sv ====
`default_nettype none

module spu_op_mem_sp #(
    parameter int  LATENCY   = 1,
    parameter int  ADDR_BITS = 8,
    parameter type data_t    = logic [7:0]
) (
    input  var logic                 clk,
    input  var logic [ADDR_BITS-1:0] addr,
    input  var data_t                wdata,
    input  var logic                 wvalid,
    output data_t                    rdata
);

    data_t mem [2**ADDR_BITS];  // scratch array
    data_t st0_rdata;           // first read stage

    // one port, write has priority over read
    always_ff @(posedge clk) begin
        if (wvalid) begin
            mem[addr] <= wdata;
        end else begin
            st0_rdata <= mem[addr];  // held while writing
        end
    end

    // remaining read stages
    spu_op_nop #(
        .LATENCY (LATENCY - 1),
        .data_t  (data_t)
    ) nop_inst (
        .clk      (clk),
        .in_data  (st0_rdata),
        .out_data (rdata)
    );

endmodule

`default_nettype wire

// ==== spu_op_alu.sv ====
`default_nettype none

module spu_op_alu
    import spu_pkg::*;
#(
    parameter int DATA_BITS = 16
) (
    input  var logic                 clk,
    input  var logic                 rst_n,
    input  var spu_op_e              op,
    input  var logic [DATA_BITS-1:0] operand,
    input  var logic [DATA_BITS-1:0] in_data,
    input  var logic                 in_valid,
    output logic [DATA_BITS-1:0]     out_data,
    output logic                     out_valid
);

    logic [DATA_BITS:0]   sum;     // carry in top bit
    logic [DATA_BITS-1:0] result;

    always_comb begin
        sum = {1'b0, in_data} + {1'b0, operand};
        case (op)
            OP_COPY: result = in_data;
            OP_ADDS: result = sum[DATA_BITS] ? '1 : sum[DATA_BITS-1:0];
            OP_SUBS: result = (operand > in_data) ? '0 : in_data - operand;
            OP_XOR:  result = in_data ^ operand;
            default: result = in_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;  // one cycle behind input
        end
    end

endmodule

`default_nettype wire

// ==== spu_ctrl.sv ====
`default_nettype none

module spu_ctrl
    import spu_pkg::*;
#(
    parameter int DATA_BITS = 16,
    parameter int ADDR_BITS = 6,
    parameter int LATENCY   = 2
) (
    input  var logic                 clk,
    input  var logic                 rst_n,
    input  var logic                 cyc,
    input  var logic                 stb,
    input  var logic                 we,
    input  var logic [ADDR_BITS:0]   adr,
    input  var logic [DATA_BITS-1:0] dat_w,
    output logic [DATA_BITS-1:0]     dat_r,
    output logic                     ack,
    output logic [ADDR_BITS-1:0]     mem_addr,
    output logic [DATA_BITS-1:0]     mem_wdata,
    output logic                     mem_wvalid,
    input  var logic [DATA_BITS-1:0] mem_rdata,
    output spu_op_e                  alu_op,
    output logic [DATA_BITS-1:0]     alu_operand,
    output logic [DATA_BITS-1:0]     alu_in,
    output logic                     alu_valid,
    input  var logic [DATA_BITS-1:0] alu_out,
    input  var logic                 alu_out_valid
);

    localparam int CNT_BITS = $clog2(LATENCY + 1);  // must hold LATENCY

    typedef enum logic [3:0] {
        ST_IDLE, ST_HRD, ST_HWR, ST_START, ST_LEN, ST_RD, ST_WAIT, ST_ALU, ST_WR
    } state_e;

    state_e               state;
    logic [CNT_BITS-1:0]  wait_cnt;
    logic [DATA_BITS-1:0] src_reg;
    logic [DATA_BITS-1:0] dst_reg;
    logic [DATA_BITS-1:0] len_reg;
    logic [DATA_BITS-1:0] operand_reg;
    spu_op_e              op_reg;
    logic                 busy;
    logic                 done;
    logic [DATA_BITS-1:0] idx;       // element index
    logic [DATA_BITS-1:0] idx_next;
    logic                 req;
    logic                 reg_req;
    logic                 mem_req;
    logic                 hrd_last;  // host read data arrives
    spu_reg_e             reg_sel;
    logic [DATA_BITS-1:0] reg_rdata;

    assign req      = cyc & stb & ~ack;  // no second ack on a held strobe
    assign reg_req  = req & adr[ADDR_BITS];
    assign mem_req  = req & ~adr[ADDR_BITS];
    assign reg_sel  = spu_reg_e'(adr[2:0]);
    assign idx_next = idx + 1'b1;
    assign hrd_last = (state == ST_HRD) && (wait_cnt == CNT_BITS'(1));

    always_comb begin
        reg_rdata = '0;
        case (reg_sel)
            REG_SRC:    reg_rdata = src_reg;
            REG_DST:    reg_rdata = dst_reg;
            REG_LEN:    reg_rdata = len_reg;
            REG_ADDEND: reg_rdata = operand_reg;
            REG_CTRL:   reg_rdata[CTRL_OP_LSB +: 2] = op_reg;  // start reads as zero
            REG_STATUS: begin
                reg_rdata[STATUS_BUSY_BIT] = busy;
                reg_rdata[STATUS_DONE_BIT] = done;
            end
            default:    reg_rdata = '0;
        endcase
    end

    // memory port, host address unless the job owns it
    always_comb begin
        mem_addr   = adr[ADDR_BITS-1:0];
        mem_wdata  = dat_w;
        mem_wvalid = 1'b0;
        case (state)
            ST_HWR: mem_wvalid = 1'b1;
            ST_RD:  mem_addr = ADDR_BITS'(src_reg + idx);  // wraps at array end
            ST_WR: begin
                mem_addr   = ADDR_BITS'(dst_reg + idx);
                mem_wdata  = alu_out;
                mem_wvalid = alu_out_valid;
            end
            default: ;
        endcase
    end

    assign alu_op      = op_reg;
    assign alu_operand = operand_reg;
    assign alu_in      = mem_rdata;
    assign alu_valid   = (state == ST_ALU);

    always_ff @(posedge clk) begin
        if (reg_req) begin
            dat_r <= reg_rdata;
        end else if (hrd_last) begin
            dat_r <= mem_rdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            ack         <= 1'b0;
            wait_cnt    <= '0;
            src_reg     <= '0;
            dst_reg     <= '0;
            len_reg     <= '0;
            operand_reg <= '0;
            op_reg      <= OP_COPY;
            busy        <= 1'b0;
            done        <= 1'b0;
            idx         <= '0;
        end else begin
            ack <= 1'b0;
            // registers answer in every state, writes only land while idle
            if (reg_req) begin
                ack <= 1'b1;
                if (we && state == ST_IDLE) begin
                    case (reg_sel)
                        REG_SRC:    src_reg <= dat_w;
                        REG_DST:    dst_reg <= dat_w;
                        REG_LEN:    len_reg <= dat_w;
                        REG_ADDEND: operand_reg <= dat_w;
                        REG_CTRL:   op_reg <= spu_op_e'(dat_w[CTRL_OP_LSB +: 2]);
                        default: ;
                    endcase
                end
            end
            case (state)
                ST_IDLE: begin
                    if (reg_req && we && reg_sel == REG_CTRL && dat_w[CTRL_START_BIT]) begin
                        state <= ST_START;
                    end else if (mem_req && we) begin
                        ack   <= 1'b1;  // ack with the write itself
                        state <= ST_HWR;
                    end else if (mem_req) begin
                        wait_cnt <= CNT_BITS'(LATENCY);
                        state    <= ST_HRD;
                    end
                end
                ST_HRD: begin
                    wait_cnt <= wait_cnt - 1'b1;
                    if (hrd_last) begin
                        ack   <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                ST_HWR: state <= ST_IDLE;
                ST_START: begin
                    busy  <= 1'b1;
                    done  <= 1'b0;
                    idx   <= '0;
                    state <= ST_LEN;
                end
                ST_LEN: begin
                    if (len_reg == '0) begin  // empty job
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end else begin
                        state <= ST_RD;
                    end
                end
                ST_RD: begin
                    wait_cnt <= CNT_BITS'(LATENCY - 1);
                    state    <= (LATENCY > 1) ? ST_WAIT : ST_ALU;
                end
                ST_WAIT: begin
                    wait_cnt <= wait_cnt - 1'b1;
                    if (wait_cnt == CNT_BITS'(1)) begin
                        state <= ST_ALU;
                    end
                end
                ST_ALU: state <= ST_WR;  // read data at operator input
                ST_WR: begin
                    if (alu_out_valid) begin
                        idx <= idx_next;
                        if (idx_next == len_reg) begin
                            busy  <= 1'b0;
                            done  <= 1'b1;
                            state <= ST_IDLE;
                        end else begin
                            state <= ST_RD;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== spu_top.sv ====
`default_nettype none

module spu_top
    import spu_pkg::*;
#(
    parameter int DATA_BITS = 16,
    parameter int ADDR_BITS = 6,
    parameter int LATENCY   = 2
) (
    input  var logic                 clk,
    input  var logic                 rst_n,
    input  var logic                 cyc,
    input  var logic                 stb,
    input  var logic                 we,
    input  var logic [ADDR_BITS:0]   adr,
    input  var logic [DATA_BITS-1:0] dat_w,
    output logic [DATA_BITS-1:0]     dat_r,
    output logic                     ack
);

    localparam type data_t = logic [DATA_BITS-1:0];  // memory payload

    logic [ADDR_BITS-1:0] mem_addr;
    data_t                mem_wdata;
    logic                 mem_wvalid;
    data_t                mem_rdata;
    spu_op_e              alu_op;
    logic [DATA_BITS-1:0] alu_operand;
    logic [DATA_BITS-1:0] alu_in;
    logic                 alu_valid;
    logic [DATA_BITS-1:0] alu_out;
    logic                 alu_out_valid;

    spu_ctrl #(
        .DATA_BITS (DATA_BITS),
        .ADDR_BITS (ADDR_BITS),
        .LATENCY   (LATENCY)
    ) ctrl_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .cyc           (cyc),
        .stb           (stb),
        .we            (we),
        .adr           (adr),
        .dat_w         (dat_w),
        .dat_r         (dat_r),
        .ack           (ack),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_wvalid    (mem_wvalid),
        .mem_rdata     (mem_rdata),
        .alu_op        (alu_op),
        .alu_operand   (alu_operand),
        .alu_in        (alu_in),
        .alu_valid     (alu_valid),
        .alu_out       (alu_out),
        .alu_out_valid (alu_out_valid)
    );

    spu_op_mem_sp #(
        .LATENCY   (LATENCY),
        .ADDR_BITS (ADDR_BITS),
        .data_t    (data_t)
    ) mem_inst (
        .clk    (clk),
        .addr   (mem_addr),
        .wdata  (mem_wdata),
        .wvalid (mem_wvalid),
        .rdata  (mem_rdata)
    );

    spu_op_alu #(
        .DATA_BITS (DATA_BITS)
    ) alu_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (alu_op),
        .operand   (alu_operand),
        .in_data   (alu_in),
        .in_valid  (alu_valid),
        .out_data  (alu_out),
        .out_valid (alu_out_valid)
    );

endmodule

`default_nettype wire

// ==== tb_spu_top.sv ====
`default_nettype none

module tb_spu_top
    import spu_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_BITS = 16;
    localparam int ADDR_BITS = 6;
    localparam int LATENCY   = 2;
    localparam int MEM_WORDS = 2**ADDR_BITS;
    localparam int WORD_BUS  = LATENCY + 4;  // worst cycles per host memory access
    localparam int ROW_BUS   = 48;           // register traffic per job

    typedef struct packed {
        logic [DATA_BITS-1:0] src;
        logic [DATA_BITS-1:0] dst;
        logic [DATA_BITS-1:0] len;
        logic [DATA_BITS-1:0] operand;
        spu_op_e              op;
        logic                 probe;  // host read while busy
    } job_t;

    // src, dst, len, operand, op, probe
    localparam job_t JOBS [6] = '{
        '{16'd0,  16'd16, 16'd8, 16'h0000, OP_COPY, 1'b0},
        '{16'd4,  16'd20, 16'd6, 16'hf000, OP_ADDS, 1'b0},  // clips most words
        '{16'd8,  16'd30, 16'd5, 16'ha5a5, OP_XOR,  1'b1},
        '{16'd10, 16'd11, 16'd6, 16'h8000, OP_SUBS, 1'b0},  // dst one word ahead
        '{16'd0,  16'd40, 16'd0, 16'h0000, OP_COPY, 1'b0},  // empty job
        '{16'd60, 16'd62, 16'd7, 16'h1234, OP_ADDS, 1'b1}   // runs past word 63
    };

    logic                 clk;
    logic                 rst_n;
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [ADDR_BITS:0]   adr;
    logic [DATA_BITS-1:0] dat_w;
    logic [DATA_BITS-1:0] dat_r;
    logic                 ack;

    logic [DATA_BITS-1:0] model [MEM_WORDS];
    logic [31:0]          lfsr_state = 32'h8359;
    int                   cycle_cnt = 0;
    int                   cycle_limit;
    int                   ack_cycle;
    int                   value_errors = 0;
    int                   other_errors = 0;

    spu_top #(
        .DATA_BITS (DATA_BITS),
        .ADDR_BITS (ADDR_BITS),
        .LATENCY   (LATENCY)
    ) spu_top_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int run_limit();
        int sum;
        sum = 16 + 2 * MEM_WORDS * WORD_BUS + ROW_BUS;  // reset and first fill
        foreach (JOBS[r]) begin
            sum += JOBS[r].len * (LATENCY + 2) + ROW_BUS;
            sum += (JOBS[r].len + MEM_WORDS + 1) * WORD_BUS;
        end
        return 2 * sum;
    endfunction

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == cycle_limit) begin
            $display("timeout after %0d cycles, a bus cycle or job never finished", cycle_cnt);
            $display("errors: %0d value, %0d other", value_errors, other_errors + 1);
            $display("sim failed");
            $finish;
        end
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [DATA_BITS-1:0] rand_word();
        logic [DATA_BITS-1:0] w;
        for (int b = 0; b < DATA_BITS; b++) begin
            w[b]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
        end
        return w;
    endfunction

    function automatic logic [DATA_BITS-1:0] apply_op(input spu_op_e op,
                                                      input logic [DATA_BITS-1:0] operand,
                                                      input logic [DATA_BITS-1:0] v);
        int wide;
        case (op)
            OP_ADDS: begin
                wide = int'(v) + int'(operand);
                return (wide > 2**DATA_BITS - 1) ? '1 : DATA_BITS'(wide);
            end
            OP_SUBS: return (v < operand) ? '0 : v - operand;
            OP_XOR:  return v ^ operand;
            default: return v;
        endcase
    endfunction

    // forward loop, addresses modulo the memory size
    task automatic run_model(input job_t job);
        int s;
        int d;
        for (int i = 0; i < int'(job.len); i++) begin
            s        = (int'(job.src) + i) % MEM_WORDS;
            d        = (int'(job.dst) + i) % MEM_WORDS;
            model[d] = apply_op(job.op, job.operand, model[s]);
        end
    endtask

    task automatic wait_ack();
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        ack_cycle = cycle_cnt;
    endtask

    task automatic bus_write(input logic [ADDR_BITS:0] a, input logic [DATA_BITS-1:0] d);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        dat_w = d;
        wait_ack();
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        @(negedge clk);  // idle gap between cycles
    endtask

    task automatic bus_read(input logic [ADDR_BITS:0] a, output logic [DATA_BITS-1:0] d);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        wait_ack();
        d   = dat_r;
        cyc = 1'b0;
        stb = 1'b0;
        @(negedge clk);
    endtask

    function automatic logic [ADDR_BITS:0] reg_adr(input spu_reg_e r);
        logic [ADDR_BITS:0] a;
        a            = '0;
        a[ADDR_BITS] = 1'b1;  // register window
        a[2:0]       = r;
        return a;
    endfunction

    task automatic check_word(input string name, input logic [DATA_BITS-1:0] exp,
                              input logic [DATA_BITS-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_status(input logic exp_busy, input logic exp_done,
                                input logic [DATA_BITS-1:0] st);
        if (st[STATUS_BUSY_BIT] !== exp_busy) begin
            $display("[ERROR] status.busy expected %h got %h", exp_busy, st[STATUS_BUSY_BIT]);
            value_errors++;
        end
        if (st[STATUS_DONE_BIT] !== exp_done) begin
            $display("[ERROR] status.done expected %h got %h", exp_done, st[STATUS_DONE_BIT]);
            value_errors++;
        end
    endtask

    task automatic check_memory();
        logic [DATA_BITS-1:0] w;
        for (int a = 0; a < MEM_WORDS; a++) begin
            bus_read({1'b0, ADDR_BITS'(a)}, w);
            check_word($sformatf("mem[%0d]", a), model[a], w);
        end
    endtask

    initial begin : main
        logic [DATA_BITS-1:0] w;
        logic [DATA_BITS-1:0] st;
        job_t                 job;
        int                   a;
        int                   start_cycle;
        cycle_limit = run_limit();
        rst_n = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        if (LATENCY < 1) begin
            $display("memory read latency is below one cycle, the design needs at least one");
            other_errors++;
        end

        bus_read(reg_adr(REG_STATUS), st);
        check_status(1'b0, 1'b0, st);
        for (int r = REG_SRC; r <= REG_ADDEND; r++) begin
            bus_read(reg_adr(spu_reg_e'(r)), w);
            check_word($sformatf("reg[%0d]", r), '0, w);
        end
        for (a = 0; a < MEM_WORDS; a++) begin
            model[a] = rand_word();
            bus_write({1'b0, ADDR_BITS'(a)}, model[a]);
        end
        check_memory();

        foreach (JOBS[r]) begin
            job = JOBS[r];
            for (int i = 0; i < int'(job.len); i++) begin
                a        = (int'(job.src) + i) % MEM_WORDS;
                model[a] = rand_word();
                bus_write({1'b0, ADDR_BITS'(a)}, model[a]);
            end
            bus_write(reg_adr(REG_SRC), job.src);
            bus_write(reg_adr(REG_DST), job.dst);
            bus_write(reg_adr(REG_LEN), job.len);
            bus_write(reg_adr(REG_ADDEND), job.operand);
            w                           = '0;
            w[CTRL_START_BIT]           = 1'b1;
            w[CTRL_OP_LSB +: 2]         = job.op;
            bus_write(reg_adr(REG_CTRL), w);
            start_cycle = ack_cycle;
            run_model(job);

            bus_read(reg_adr(REG_STATUS), st);  // done from last job now cleared
            check_status(1'b1, 1'b0, st);

            if (job.probe) begin
                a = (int'(job.dst) + int'(job.len) - 1) % MEM_WORDS;
                bus_read({1'b0, ADDR_BITS'(a)}, w);
                if (ack_cycle - start_cycle <= int'(job.len) * (LATENCY + 2) + 2) begin
                    $display("host read of word %0d was acknowledged before job %0d ended",
                             a, r);
                    other_errors++;
                end
                check_word($sformatf("probe mem[%0d]", a), model[a], w);
            end

            do begin
                bus_read(reg_adr(REG_STATUS), st);
            end while (!st[STATUS_DONE_BIT]);
            check_status(1'b0, 1'b1, st);
            bus_read(reg_adr(REG_STATUS), st);  // sticky done
            check_status(1'b0, 1'b1, st);
            check_memory();
        end

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
spu_pkg.sv
spu_op_nop.sv
spu_op_mem_sp.sv
spu_op_alu.sv
spu_ctrl.sv
spu_top.sv
tb_spu_top.sv

// ==== Bender.yml ====
package:
  name: spu

sources:
  - spu_pkg.sv
  - spu_op_nop.sv
  - spu_op_mem_sp.sv
  - spu_op_alu.sv
  - spu_ctrl.sv
  - spu_top.sv
  - target: test
    files:
      - tb_spu_top.sv
